/* logic/flight_types_pkg.sv */
//##########################################################
// Flight datapath widths and the receiver, IMU and
// velocity value types
//##########################################################
package flight_types_pkg;

    // Receiver and PWM throttle values
    localparam int unsigned REC_VAL_W = 8;

    // IMU vertical linear acceleration, 0.01 m/s^2 per LSB
    localparam int unsigned IMU_VAL_W = 16;

    // Vertical velocity as reported out of the block
    localparam int unsigned RATE_W = 16;

    // Q16.16 velocity accumulator
    localparam int unsigned VEL_FRAC_W = 16;
    localparam int unsigned VEL_ACC_W  = RATE_W + VEL_FRAC_W;

    typedef logic [REC_VAL_W-1:0] rec_val_t;

    typedef logic signed [IMU_VAL_W-1:0] imu_val_t;

    // Upper half of the accumulator
    typedef logic signed [RATE_W-1:0] rate_t;

    typedef logic signed [VEL_ACC_W-1:0] vel_acc_t;

endpackage : flight_types_pkg

/* logic/amc_ctrl_pkg.sv */
//##########################################################
// Auto mode controller state encoding and the shift taps
// of the fixed-point velocity integration
//##########################################################
package amc_ctrl_pkg;

    localparam int unsigned AMC_NUM_STATES = 7;

    // One-hot controller states
    typedef enum logic [AMC_NUM_STATES-1:0] {
        ST_INIT          = 7'b000_0001,
        ST_NOT_AUTO      = 7'b000_0010,
        ST_WAIT_AUTO     = 7'b000_0100,
        ST_LATCH         = 7'b000_1000,
        ST_CALC_VELOCITY = 7'b001_0000,
        ST_UP_DOWN       = 7'b010_0000,
        ST_COMPLETE      = 7'b100_0000
    } amc_state_t;

    // 0.01 m/s^2 per bit times a 40 ms step gives a factor of 0.0004
    // 0.0004 = 0.00000000000110100011011011100010 in binary
    // Each set bit becomes one arithmetic right shift of the Q16.16 word
    localparam int unsigned VEL_NUM_TAPS = 11;

    localparam int unsigned VEL_SHIFT_TAPS [VEL_NUM_TAPS] = '{
        12, 13, 15, 19, 20, 22, 23, 25, 26, 27, 31
    };

endpackage : amc_ctrl_pkg

/* logic/ms_tick_gen.sv */
//##########################################################
// Millisecond tick generator driven from the 1 MHz clock
//##########################################################
`timescale 1ns/1ps

module ms_tick_gen #(
    parameter int unsigned CLKS_PER_MS = 1000
) (
    input  logic us_clk,
    input  logic resetn,
    output logic ms_tick
);

    localparam int unsigned CNT_W = $clog2(CLKS_PER_MS + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_MS - 1);

    logic [CNT_W-1:0] clk_count;

    // Free-running modulo counter, tick registered on the last count
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            clk_count <= '0;
            ms_tick   <= 1'b0;
        end else begin
            ms_tick <= (clk_count == CNT_LAST);
            if (clk_count == CNT_LAST) begin
                clk_count <= '0;
            end else begin
                clk_count <= clk_count + 1'b1;
            end
        end
    end

endmodule : ms_tick_gen

/* logic/hold_timer.sv */
//##########################################################
// Cooldown countdown in milliseconds with a wrap flag
//##########################################################
`timescale 1ns/1ps

module hold_timer #(
    parameter int unsigned HOLD_MS = 10000
) (
    input  logic us_clk,
    input  logic resetn,
    input  logic ms_tick,
    input  logic hold_reload,
    output logic hold_expired
);

    // One spare bit on top so the wrap below zero lands in the MSB
    localparam int unsigned HOLD_W = $clog2(HOLD_MS + 1) + 1;
    localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(HOLD_MS);

    logic [HOLD_W-1:0] hold_count;

    // Reset leaves the timer expired at all ones
    // Counting stops once the count has wrapped
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            hold_count <= '1;
        end else if (hold_reload) begin
            hold_count <= HOLD_LOAD;
        end else if (ms_tick && !hold_count[HOLD_W-1]) begin
            hold_count <= hold_count - 1'b1;
        end
    end

    assign hold_expired = hold_count[HOLD_W-1];

endmodule : hold_timer

/* logic/z_velocity_integrator.sv */
//##########################################################
// Vertical velocity integrator, Q16.16 accumulator fed by
// the latched vertical acceleration
//##########################################################
`timescale 1ns/1ps

module z_velocity_integrator (
    input  logic                       us_clk,
    input  logic                       resetn,
    input  logic                       vel_step,
    input  flight_types_pkg::imu_val_t accel,
    output flight_types_pkg::rate_t    z_linear_velocity
);

    import flight_types_pkg::*;
    import amc_ctrl_pkg::*;

    vel_acc_t accel_word;
    vel_acc_t vel_delta;
    vel_acc_t vel_acc;

    // Acceleration sits in the integer half of the Q16.16 word
    assign accel_word = {accel, {VEL_FRAC_W{1'b0}}};

    // Sum of arithmetic shifts approximates accel * 0.0004
    always_comb begin
        vel_delta = '0;
        for (int i = 0; i < VEL_NUM_TAPS; i++) begin
            vel_delta = vel_delta + (accel_word >>> VEL_SHIFT_TAPS[i]);
        end
    end

    // Accumulator wraps in two's complement
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            vel_acc <= '0;
        end else if (vel_step) begin
            vel_acc <= vel_acc + vel_delta;
        end
    end

    // Integer part is the reported velocity
    assign z_linear_velocity = vel_acc[VEL_ACC_W-1 -: RATE_W];

endmodule : z_velocity_integrator

/* logic/auto_mode_controller.sv */
//##########################################################
// Auto mode FSM with start latch, input capture, throttle
// nudge and the active, complete and hold status outputs
//##########################################################
`timescale 1ns/1ps

module auto_mode_controller #(
    parameter int unsigned THROTTLE_STEP = 8
) (
    input  logic                       us_clk,
    input  logic                       resetn,
    input  logic                       imu_good,
    input  logic                       start_signal,
    input  logic                       auto_enable,
    input  logic                       climb,
    input  flight_types_pkg::imu_val_t z_linear_accel,
    input  flight_types_pkg::rec_val_t throttle_pwm_val_in,
    input  logic                       hold_expired,
    output logic                       vel_step,
    output flight_types_pkg::imu_val_t accel_latched,
    output logic                       hold_reload,
    output flight_types_pkg::rec_val_t throttle_pwm_val_out,
    output logic                       active_signal,
    output logic                       complete_signal,
    output logic                       auto_hold
);

    import flight_types_pkg::*;
    import amc_ctrl_pkg::*;

    localparam logic [REC_VAL_W:0] STEP_EXT = (REC_VAL_W + 1)'(THROTTLE_STEP);

    amc_state_t state;
    amc_state_t next_state;

    logic start_d;
    logic start_flag;
    logic start_held;

    rec_val_t         throttle_latched;
    rec_val_t         throttle_cmd;
    rec_val_t         throttle_adj;
    logic [REC_VAL_W:0] throttle_up;
    logic [REC_VAL_W:0] throttle_dn;

    // Start latch
    // A held start level keeps the flag for at most one more step
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            start_d    <= 1'b0;
            start_flag <= 1'b0;
            start_held <= 1'b0;
        end else begin
            start_d <= start_signal;
            if (state == ST_INIT) begin
                // No steps before the IMU is good
                start_flag <= 1'b0;
                start_held <= 1'b0;
            end else if (start_signal && !start_d) begin
                start_flag <= 1'b1;
                start_held <= 1'b0;
            end else if (state == ST_LATCH) begin
                if (!start_signal || start_held) begin
                    start_flag <= 1'b0;
                    start_held <= 1'b0;
                end else begin
                    start_held <= 1'b1;
                end
            end else if (start_held && !start_signal) begin
                start_flag <= 1'b0;
                start_held <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_INIT: begin
                if (imu_good) begin
                    next_state = ST_NOT_AUTO;
                end
            end
            ST_NOT_AUTO: begin
                if (start_flag) begin
                    next_state = ST_LATCH;
                end
            end
            ST_WAIT_AUTO: begin
                if (start_flag) begin
                    next_state = ST_LATCH;
                end else if (hold_expired) begin
                    next_state = ST_NOT_AUTO;
                end
            end
            ST_LATCH:         next_state = ST_CALC_VELOCITY;
            ST_CALC_VELOCITY: next_state = auto_enable ? ST_UP_DOWN : ST_NOT_AUTO;
            ST_UP_DOWN:       next_state = ST_COMPLETE;
            ST_COMPLETE:      next_state = hold_expired ? ST_NOT_AUTO : ST_WAIT_AUTO;
            default:          next_state = ST_INIT;
        endcase
    end

    // Throttle nudge with saturation at both ends
    always_comb begin
        throttle_up = {1'b0, throttle_latched} + STEP_EXT;
        throttle_dn = {1'b0, throttle_latched} - STEP_EXT;
        if (climb) begin
            throttle_adj = throttle_up[REC_VAL_W] ? '1 : throttle_up[REC_VAL_W-1:0];
        end else begin
            throttle_adj = throttle_dn[REC_VAL_W] ? '0 : throttle_dn[REC_VAL_W-1:0];
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            state                <= ST_INIT;
            active_signal        <= 1'b0;
            complete_signal      <= 1'b0;
            throttle_cmd         <= '0;
            throttle_pwm_val_out <= '0;
        end else begin
            state           <= next_state;
            active_signal   <= (state == ST_UP_DOWN);
            complete_signal <= (state == ST_COMPLETE);
            if (state == ST_UP_DOWN) begin
                throttle_cmd <= throttle_adj;
            end
            if (state == ST_NOT_AUTO || state == ST_WAIT_AUTO) begin
                throttle_pwm_val_out <= throttle_cmd;
            end
        end
    end

    // Input capture for the step
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            accel_latched    <= '0;
            throttle_latched <= '0;
        end else if (state == ST_LATCH) begin
            accel_latched    <= z_linear_accel;
            throttle_latched <= throttle_pwm_val_in;
        end
    end

    assign vel_step    = (state == ST_CALC_VELOCITY);
    assign hold_reload = (state == ST_NOT_AUTO);
    assign auto_hold   = (state == ST_WAIT_AUTO);

endmodule : auto_mode_controller

/* logic/auto_mode_top.sv */
//##########################################################
// Altitude-step top level, controller with integrator,
// cooldown timer and millisecond tick
//##########################################################
`timescale 1ns/1ps

module auto_mode_top #(
    parameter int unsigned CLKS_PER_MS   = 1000,
    parameter int unsigned HOLD_MS       = 10000,
    parameter int unsigned THROTTLE_STEP = 8
) (
    input  logic                       us_clk,
    input  logic                       resetn,
    input  logic                       imu_good,
    input  flight_types_pkg::imu_val_t z_linear_accel,
    input  flight_types_pkg::rec_val_t throttle_pwm_val_in,
    input  logic [2:0]                 switch_a,
    input  logic [1:0]                 switch_b,
    input  logic                       start_signal,
    output flight_types_pkg::rec_val_t throttle_pwm_val_out,
    output logic                       active_signal,
    output logic                       complete_signal,
    output logic                       auto_hold,
    output flight_types_pkg::rate_t    z_linear_velocity
);

    import flight_types_pkg::*;

    logic     ms_tick;
    logic     hold_reload;
    logic     hold_expired;
    logic     vel_step;
    imu_val_t accel_latched;
    logic     auto_enable;
    logic     climb;

    // Receiver switches, other bits reserved
    assign auto_enable = switch_a[1];
    assign climb       = switch_b[0];

    ms_tick_gen #(
        .CLKS_PER_MS (CLKS_PER_MS)
    ) u_ms_tick_gen (
        .us_clk  (us_clk),
        .resetn  (resetn),
        .ms_tick (ms_tick)
    );

    hold_timer #(
        .HOLD_MS (HOLD_MS)
    ) u_hold_timer (
        .us_clk       (us_clk),
        .resetn       (resetn),
        .ms_tick      (ms_tick),
        .hold_reload  (hold_reload),
        .hold_expired (hold_expired)
    );

    z_velocity_integrator u_z_velocity_integrator (
        .us_clk            (us_clk),
        .resetn            (resetn),
        .vel_step          (vel_step),
        .accel             (accel_latched),
        .z_linear_velocity (z_linear_velocity)
    );

    auto_mode_controller #(
        .THROTTLE_STEP (THROTTLE_STEP)
    ) u_auto_mode_controller (
        .us_clk               (us_clk),
        .resetn               (resetn),
        .imu_good             (imu_good),
        .start_signal         (start_signal),
        .auto_enable          (auto_enable),
        .climb                (climb),
        .z_linear_accel       (z_linear_accel),
        .throttle_pwm_val_in  (throttle_pwm_val_in),
        .hold_expired         (hold_expired),
        .vel_step             (vel_step),
        .accel_latched        (accel_latched),
        .hold_reload          (hold_reload),
        .throttle_pwm_val_out (throttle_pwm_val_out),
        .active_signal        (active_signal),
        .complete_signal      (complete_signal),
        .auto_hold            (auto_hold)
    );

endmodule : auto_mode_top

/* verification/amc_clock_gen.sv */
//##########################################################
// Testbench clock and active-low reset source
//##########################################################
`timescale 1ns/1ps

module amc_clock_gen #(
    parameter int unsigned PERIOD_NS    = 4,
    parameter int unsigned RESET_CYCLES = 2
) (
    output logic us_clk,
    output logic resetn
);

    initial begin
        us_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) us_clk = ~us_clk;
        end
    end

    // Release reset shortly after a rising edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge us_clk);
        #1 resetn = 1'b1;
    end

endmodule : amc_clock_gen

/* verification/amc_tb.sv */
//##########################################################
// Testbench for the altitude-step block with reference
// models, compare tasks, timeout and summary
//##########################################################
`timescale 1ns/1ps

module amc_tb;

    import flight_types_pkg::*;
    import amc_ctrl_pkg::*;

    localparam int unsigned CLKS_PER_MS   = 4;
    localparam int unsigned HOLD_MS       = 8;
    localparam int unsigned THROTTLE_STEP = 8;
    localparam int MAX_CYCLES = 4000;
    localparam int HOLD_MIN   = (HOLD_MS - 1) * CLKS_PER_MS;
    localparam int HOLD_MAX   = (HOLD_MS + 1) * CLKS_PER_MS;
    localparam int SEED_INIT  = 32'h4616_4430;

    logic     us_clk;
    logic     resetn;
    logic     imu_good;
    imu_val_t z_linear_accel;
    rec_val_t throttle_pwm_val_in;
    logic [2:0] switch_a;
    logic [1:0] switch_b;
    logic     start_signal;
    rec_val_t throttle_pwm_val_out;
    logic     active_signal;
    logic     complete_signal;
    logic     auto_hold;
    rate_t    z_linear_velocity;

    int seed;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int active_count = 0;
    int complete_count = 0;
    int steps_checked = 0;

    // Reference state and the expectations waiting for a complete pulse
    vel_acc_t model_acc;
    rec_val_t exp_thr_out;
    string    name_q[$];
    rate_t    vel_q[$];
    rec_val_t thr_q[$];

    logic     active_prev = 1'b0;
    logic     complete_prev = 1'b0;
    logic     thr_pending = 1'b0;
    string    pending_name;
    rec_val_t pending_thr;

    amc_clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (2)
    ) u_clock_gen (
        .us_clk (us_clk),
        .resetn (resetn)
    );

    auto_mode_top #(
        .CLKS_PER_MS   (CLKS_PER_MS),
        .HOLD_MS       (HOLD_MS),
        .THROTTLE_STEP (THROTTLE_STEP)
    ) u_auto_mode_top (
        .us_clk               (us_clk),
        .resetn               (resetn),
        .imu_good             (imu_good),
        .z_linear_accel       (z_linear_accel),
        .throttle_pwm_val_in  (throttle_pwm_val_in),
        .switch_a             (switch_a),
        .switch_b             (switch_b),
        .start_signal         (start_signal),
        .throttle_pwm_val_out (throttle_pwm_val_out),
        .active_signal        (active_signal),
        .complete_signal      (complete_signal),
        .auto_hold            (auto_hold),
        .z_linear_velocity    (z_linear_velocity)
    );

    // Acceleration in the integer half of Q16.16, scaled by the shift taps
    function automatic vel_acc_t ref_velocity(input vel_acc_t acc, input imu_val_t accel);
        vel_acc_t word;
        vel_acc_t delta;
        word  = vel_acc_t'(accel) <<< VEL_FRAC_W;
        delta = '0;
        for (int i = 0; i < int'(VEL_NUM_TAPS); i++) begin
            delta = delta + (word >>> VEL_SHIFT_TAPS[i]);
        end
        return acc + delta;
    endfunction

    function automatic rec_val_t ref_throttle(input rec_val_t thr, input logic up);
        int t;
        if (up) begin
            t = int'(thr) + int'(THROTTLE_STEP);
        end else begin
            t = int'(thr) - int'(THROTTLE_STEP);
        end
        if (t > (1 << REC_VAL_W) - 1) begin
            t = (1 << REC_VAL_W) - 1;
        end
        if (t < 0) begin
            t = 0;
        end
        return rec_val_t'(t);
    endfunction

    task automatic check_rate(input string name, input rate_t expected, input rate_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_rec(input string name, input rec_val_t expected, input rec_val_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s expected %0b actual %0b", name, expected, actual);
        end
    endtask

    // Caller sits just after a rising edge
    task automatic pulse_start();
        start_signal = 1'b1;
        @(posedge us_clk);
        #1;
        start_signal = 1'b0;
    endtask

    task automatic run_step(input string name, input imu_val_t accel, input rec_val_t thr,
                            input logic auto_en, input logic up);
        int target;
        int active_before;
        int complete_before;
        rate_t exp_vel;
        logic [2:0] rsv;
        model_acc = ref_velocity(model_acc, accel);
        exp_vel   = rate_t'(model_acc >>> VEL_FRAC_W);
        rsv       = 3'($random(seed));
        active_before   = active_count;
        complete_before = complete_count;
        @(posedge us_clk);
        #1;
        z_linear_accel      = accel;
        throttle_pwm_val_in = thr;
        // Reserved switch bits carry noise
        switch_a = {rsv[2], auto_en, rsv[0]};
        switch_b = {rsv[1], up};
        if (auto_en) begin
            exp_thr_out = ref_throttle(thr, up);
            name_q.push_back(name);
            vel_q.push_back(exp_vel);
            thr_q.push_back(exp_thr_out);
            target = steps_checked + 1;
            pulse_start();
            wait (steps_checked == target);
        end else begin
            pulse_start();
            repeat (7) @(negedge us_clk);
            check_rate({name, " velocity"}, exp_vel, z_linear_velocity);
            check_rec({name, " throttle"}, exp_thr_out, throttle_pwm_val_out);
            check_flag({name, " active seen"}, 1'b0, active_count != active_before);
            check_flag({name, " complete seen"}, 1'b0, complete_count != complete_before);
            check_flag({name, " hold"}, 1'b0, auto_hold);
        end
    endtask

    // Compare process, keyed on the complete pulse
    always @(negedge us_clk) begin
        if (thr_pending) begin
            check_rec({pending_name, " throttle"}, pending_thr, throttle_pwm_val_out);
            thr_pending = 1'b0;
            steps_checked++;
        end
        if (complete_signal) begin
            complete_count++;
            check_flag("active before complete", 1'b1, active_prev);
            check_flag("active low at complete", 1'b0, active_signal);
            check_flag("complete one cycle", 1'b0, complete_prev);
            if (name_q.size() == 0) begin
                error_count++;
                $display("complete pulse seen while no step was expected");
            end else begin
                pending_name = name_q.pop_front();
                pending_thr  = thr_q.pop_front();
                check_rate({pending_name, " velocity"}, vel_q.pop_front(), z_linear_velocity);
                thr_pending = 1'b1;
            end
        end
        if (active_signal) begin
            active_count++;
            check_flag("active one cycle", 1'b0, active_prev);
        end
        active_prev   = active_signal;
        complete_prev = complete_signal;
    end

    initial begin : watchdog
        while (cycle_count < MAX_CYCLES) begin
            @(posedge us_clk);
            cycle_count++;
        end
        error_count++;
        $display("timeout after %0d cycles, the run did not finish", cycle_count);
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        int hold_cycles;
        imu_val_t acc;
        rec_val_t thr;
        logic up;
        imu_good            = 1'b0;
        z_linear_accel      = '0;
        throttle_pwm_val_in = '0;
        switch_a            = '0;
        switch_b            = '0;
        start_signal        = 1'b0;
        seed        = SEED_INIT;
        model_acc   = '0;
        exp_thr_out = '0;
        @(posedge resetn);
        @(negedge us_clk);

        // 1. Reset values and INIT hold while the IMU is not good
        check_flag("reset active", 1'b0, active_signal);
        check_flag("reset complete", 1'b0, complete_signal);
        check_flag("reset hold", 1'b0, auto_hold);
        check_rec("reset throttle", 8'd0, throttle_pwm_val_out);
        check_rate("reset velocity", 16'sd0, z_linear_velocity);
        @(posedge us_clk);
        #1;
        switch_a = 3'b010;
        // Large enough that a stray step would move the integer velocity
        z_linear_accel = 16'sd20000;
        pulse_start();
        repeat (10) @(negedge us_clk);
        check_flag("init active seen", 1'b0, active_count != 0);
        check_rate("init velocity", 16'sd0, z_linear_velocity);
        @(posedge us_clk);
        #1;
        imu_good = 1'b1;
        repeat (2) @(negedge us_clk);

        // 2. Climb and descend, with saturation at both ends
        run_step("climb_mid", 16'sd100, 8'd120, 1'b1, 1'b1);
        run_step("descend_mid", -16'sd50, 8'd120, 1'b1, 1'b0);
        run_step("climb_sat", 16'sd0, 8'd250, 1'b1, 1'b1);
        run_step("descend_sat", 16'sd0, 8'd3, 1'b1, 1'b0);
        run_step("climb_top", 16'sd7, 8'd255, 1'b1, 1'b1);

        // 3. Random accelerations of both signs
        for (int n = 0; n < 20; n++) begin
            acc = imu_val_t'($random(seed));
            thr = rec_val_t'($random(seed));
            up  = 1'($random(seed));
            run_step($sformatf("random_%0d", n), acc, thr, 1'b1, up);
        end

        // 4. Auto switch off still integrates
        run_step("auto_off_neg", -16'sd3000, 8'd77, 1'b0, 1'b1);
        run_step("auto_off_pos", 16'sd12000, 8'd200, 1'b0, 1'b0);

        // 5. Cooldown window, then a start inside the hold
        run_step("hold_step", 16'sd400, 8'd100, 1'b1, 1'b1);
        check_flag("hold after complete", 1'b1, auto_hold);
        hold_cycles = 0;
        while (auto_hold) begin
            hold_cycles++;
            @(negedge us_clk);
        end
        if (hold_cycles < HOLD_MIN || hold_cycles > HOLD_MAX) begin
            error_count++;
            $display("auto_hold lasted %0d cycles, outside %0d to %0d",
                     hold_cycles, HOLD_MIN, HOLD_MAX);
        end
        run_step("hold_first", -16'sd900, 8'd60, 1'b1, 1'b0);
        repeat (10) @(negedge us_clk);
        check_flag("hold mid cooldown", 1'b1, auto_hold);
        run_step("start_in_hold", 16'sd2500, 8'd60, 1'b1, 1'b1);

        repeat (4) @(negedge us_clk);
        if (name_q.size() != 0) begin
            error_count++;
            $display("%0d expected steps never completed", name_q.size());
        end
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : amc_tb

/* compile.f */
logic/flight_types_pkg.sv
logic/amc_ctrl_pkg.sv
logic/ms_tick_gen.sv
logic/hold_timer.sv
logic/z_velocity_integrator.sv
logic/auto_mode_controller.sv
logic/auto_mode_top.sv
verification/amc_clock_gen.sv
verification/amc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the altitude-step testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f compile.f --top-module amc_tb \
    --Mdir obj_dir -o amc_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/amc_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
